//--- design/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath width of the integer core
`define RV_XLEN 32

// one quotient bit per divider iteration
`define RV_DIV_STEPS 32

// wide enough to hold RV_DIV_STEPS
`define RV_DIV_CNT_W 6

`endif

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// one instruction word, seen as R-type or as I-type
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} instr_u;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA,
		SLT,
		SLTU
	} alu_op_e;

	// order matches funct3[1:0] of the M-extension divides
	typedef enum logic [1:0] {
		DIV,
		DIVU,
		REM,
		REMU
	} div_op_e;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct7 groups inside OP
	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- design/decoded_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

interface decoded_if
	import rv_pkg::*;
();
	logic               valid;
	alu_op_e            alu_op;
	logic               div_valid;
	div_op_e            div_op;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]         rd;
	logic               wr_en;

	modport src (output valid, alu_op, div_valid, div_op, op_a, op_b, rd, wr_en);
	modport dst (input valid, alu_op, div_valid, div_op, op_a, op_b, rd, wr_en);

endinterface

`default_nettype wire

//--- design/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module instr_decoder
	import rv_pkg::*;
(
	input  logic                in_valid,
	input  instr_u              instr,
	input  logic [`RV_XLEN-1:0] op_a,
	input  logic [`RV_XLEN-1:0] op_b,
	decoded_if.src              dec
);

	logic supported;

	always_comb begin
		supported     = 1'b0;
		dec.alu_op    = ADD;
		dec.div_valid = 1'b0;
		dec.div_op    = DIV;
		dec.op_a      = op_a;
		dec.op_b      = op_b;
		dec.rd        = instr.r.rd;
		case (instr.r.opcode)
			OPC_OP: begin
				supported = 1'b1;
				case (instr.r.funct7)
					F7_BASE: begin
						case (instr.r.funct3)
							3'b000: dec.alu_op = ADD;
							3'b001: dec.alu_op = SLL;
							3'b010: dec.alu_op = SLT;
							3'b011: dec.alu_op = SLTU;
							3'b100: dec.alu_op = XOR;
							3'b101: dec.alu_op = SRL;
							3'b110: dec.alu_op = OR;
							default: dec.alu_op = AND;
						endcase
					end
					F7_ALT: begin
						if (instr.r.funct3 == 3'b000) begin
							dec.alu_op = SUB;
						end else if (instr.r.funct3 == 3'b101) begin
							dec.alu_op = SRA;
						end else begin
							supported = 1'b0;
						end
					end
					F7_MULDIV: begin
						// multiplies are not part of this slice
						supported     = instr.r.funct3[2];
						dec.div_valid = 1'b1;
						dec.div_op    = div_op_e'(instr.r.funct3[1:0]);
					end
					default: supported = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				supported = 1'b1;
				dec.op_b  = {{(`RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
				case (instr.i.funct3)
					3'b000: dec.alu_op = ADD;
					3'b010: dec.alu_op = SLT;
					3'b011: dec.alu_op = SLTU;
					3'b100: dec.alu_op = XOR;
					3'b110: dec.alu_op = OR;
					3'b111: dec.alu_op = AND;
					default: begin
						// shift immediates, shamt in imm12[4:0]
						dec.op_b = {{(`RV_XLEN-5){1'b0}}, instr.i.imm12[4:0]};
						if (instr.i.funct3 == 3'b001) begin
							dec.alu_op = SLL;
							supported  = (instr.i.imm12[11:5] == F7_BASE);
						end else if (instr.i.imm12[11:5] == F7_ALT) begin
							dec.alu_op = SRA;
						end else begin
							dec.alu_op = SRL;
							supported  = (instr.i.imm12[11:5] == F7_BASE);
						end
					end
				endcase
			end
			default: supported = 1'b0;
		endcase
		// x0 writes are dropped here, so they never reach execute
		dec.wr_en = supported && (instr.r.rd != 5'd0);
		dec.valid = in_valid && dec.wr_en;
	end

endmodule

`default_nettype wire

//--- design/pipereg_id_exe.sv
`timescale 1ns/1ps
`default_nettype none

module pipereg_id_exe
	import rv_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   en,
	input  logic   stall,
	input  logic   flush,
	decoded_if.dst id,
	decoded_if.src exe
);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			// bubble
			exe.valid     <= 1'b0;
			exe.alu_op    <= ADD;
			exe.div_valid <= 1'b0;
			exe.div_op    <= DIV;
			exe.op_a      <= '0;
			exe.op_b      <= '0;
			exe.rd        <= 5'd0;
			exe.wr_en     <= 1'b0;
		end else if (en && !stall) begin
			exe.valid     <= id.valid;
			exe.alu_op    <= id.alu_op;
			exe.div_valid <= id.div_valid;
			exe.div_op    <= id.div_op;
			exe.op_a      <= id.op_a;
			exe.op_b      <= id.op_b;
			exe.rd        <= id.rd;
			exe.wr_en     <= id.wr_en;
		end
	end

	// while stalled every field keeps its value

endmodule

`default_nettype wire

//--- design/div_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl_fsm (
	input  logic   clk,
	input  logic   reset,
	input  logic   flush,
	decoded_if.dst exe,
	input  logic   last,
	output logic   busy,
	output logic   load,
	output logic   step,
	output logic   done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,
		S_DONE
	} state_e;

	state_e state;
	state_e state_nxt;

	// a divide waiting in execute starts right away
	assign load = (state == S_IDLE) && exe.valid && exe.div_valid;
	assign step = (state == S_BUSY);
	assign done = (state == S_DONE);
	assign busy = load || step;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: if (load) state_nxt = S_BUSY;
			S_BUSY: if (last) state_nxt = S_DONE;
			default: state_nxt = S_IDLE;
		endcase
		if (flush) begin
			state_nxt = S_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

`default_nettype wire

//--- design/div_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module div_step_counter (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic step,
	output logic last
);

	logic [`RV_DIV_CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset || load) begin
			cnt <= '0;
		end else if (step) begin
			cnt <= cnt + 1'b1;
		end
	end

	// high during the final iteration
	assign last = step && (cnt == `RV_DIV_CNT_W'(`RV_DIV_STEPS - 1));

endmodule

`default_nettype wire

//--- design/div_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module div_datapath
	import rv_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	input  logic                load,
	input  logic                step,
	decoded_if.dst              exe,
	output logic [`RV_XLEN-1:0] div_result
);

	logic [`RV_XLEN-1:0] quot_r;
	logic [`RV_XLEN-1:0] rem_r;
	logic [`RV_XLEN-1:0] divisor_r;
	logic [`RV_XLEN-1:0] dividend_r;
	logic                neg_q_r;
	logic                neg_r_r;
	logic                zero_r;
	logic                is_signed;
	logic [`RV_XLEN-1:0] mag_a;
	logic [`RV_XLEN-1:0] mag_b;
	logic [`RV_XLEN:0]   trial;
	logic [`RV_XLEN-1:0] q_fix;
	logic [`RV_XLEN-1:0] r_fix;

	assign is_signed = (exe.div_op == DIV) || (exe.div_op == REM);
	assign mag_a     = (is_signed && exe.op_a[`RV_XLEN-1]) ? -exe.op_a : exe.op_a;
	assign mag_b     = (is_signed && exe.op_b[`RV_XLEN-1]) ? -exe.op_b : exe.op_b;

	// partial remainder with the next dividend bit shifted in
	assign trial = {rem_r, quot_r[`RV_XLEN-1]} - {1'b0, divisor_r};

	always_ff @(posedge clk) begin
		if (load) begin
			quot_r     <= mag_a;
			rem_r      <= '0;
			divisor_r  <= mag_b;
			dividend_r <= exe.op_a;
		end else if (step) begin
			if (!trial[`RV_XLEN]) begin
				rem_r  <= trial[`RV_XLEN-1:0];
				quot_r <= {quot_r[`RV_XLEN-2:0], 1'b1};
			end else begin
				rem_r  <= {rem_r[`RV_XLEN-2:0], quot_r[`RV_XLEN-1]};
				quot_r <= {quot_r[`RV_XLEN-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			neg_q_r <= 1'b0;
			neg_r_r <= 1'b0;
			zero_r  <= 1'b0;
		end else if (load) begin
			neg_q_r <= is_signed && (exe.op_a[`RV_XLEN-1] ^ exe.op_b[`RV_XLEN-1]);
			neg_r_r <= is_signed && exe.op_a[`RV_XLEN-1];
			zero_r  <= (exe.op_b == '0);
		end
	end

	// most negative / -1 needs no special case, the negated magnitude wraps back
	always_comb begin
		q_fix = neg_q_r ? -quot_r : quot_r;
		r_fix = neg_r_r ? -rem_r : rem_r;
		if (zero_r) begin
			q_fix = '1;
			r_fix = dividend_r;
		end
		case (exe.div_op)
			DIV, DIVU: div_result = q_fix;
			default:   div_result = r_fix;
		endcase
	end

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module alu_unit
	import rv_pkg::*;
(
	decoded_if.dst              exe,
	input  logic                done,
	input  logic [`RV_XLEN-1:0] div_result,
	output logic                res_valid,
	output logic [4:0]          res_rd,
	output logic [`RV_XLEN-1:0] res_data
);

	logic [`RV_XLEN-1:0] alu_result;
	logic [4:0]          shamt;

	assign shamt = exe.op_b[4:0];

	always_comb begin
		case (exe.alu_op)
			ADD:  alu_result = exe.op_a + exe.op_b;
			SUB:  alu_result = exe.op_a - exe.op_b;
			AND:  alu_result = exe.op_a & exe.op_b;
			OR:   alu_result = exe.op_a | exe.op_b;
			XOR:  alu_result = exe.op_a ^ exe.op_b;
			SLL:  alu_result = exe.op_a << shamt;
			SRL:  alu_result = exe.op_a >> shamt;
			SRA:  alu_result = $signed(exe.op_a) >>> shamt;
			SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(exe.op_a) < $signed(exe.op_b)};
			SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, exe.op_a < exe.op_b};
			default: alu_result = '0;
		endcase
	end

	// divides report only once the divider finishes
	assign res_valid = (exe.valid && exe.wr_en && !exe.div_valid) || done;
	assign res_rd    = exe.rd;
	assign res_data  = done ? div_result : alu_result;

endmodule

`default_nettype wire

//--- design/rv_idexe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_idexe_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  logic [31:0]         instr,
	input  logic [`RV_XLEN-1:0] op_a,
	input  logic [`RV_XLEN-1:0] op_b,
	input  logic                flush,
	output logic                busy,
	output logic                res_valid,
	output logic [4:0]          res_rd,
	output logic [`RV_XLEN-1:0] res_data
);

	logic                load;
	logic                step;
	logic                done;
	logic                last;
	logic [`RV_XLEN-1:0] div_result;

	decoded_if id_bus ();
	decoded_if exe_bus ();

	instr_decoder instr_decoder_i (
		.in_valid (in_valid),
		.instr    (instr),
		.op_a     (op_a),
		.op_b     (op_b),
		.dec      (id_bus.src)
	);

	// register loads every cycle unless the divider holds the front
	pipereg_id_exe pipereg_id_exe_i (
		.clk   (clk),
		.reset (reset),
		.en    (1'b1),
		.stall (busy),
		.flush (flush),
		.id    (id_bus.dst),
		.exe   (exe_bus.src)
	);

	div_ctrl_fsm div_ctrl_fsm_i (
		.clk   (clk),
		.reset (reset),
		.flush (flush),
		.exe   (exe_bus.dst),
		.last  (last),
		.busy  (busy),
		.load  (load),
		.step  (step),
		.done  (done)
	);

	div_step_counter div_step_counter_i (
		.clk   (clk),
		.reset (reset),
		.load  (load),
		.step  (step),
		.last  (last)
	);

	div_datapath div_datapath_i (
		.clk        (clk),
		.reset      (reset),
		.load       (load),
		.step       (step),
		.exe        (exe_bus.dst),
		.div_result (div_result)
	);

	alu_unit alu_unit_i (
		.exe        (exe_bus.dst),
		.done       (done),
		.div_result (div_result),
		.res_valid  (res_valid),
		.res_rd     (res_rd),
		.res_data   (res_data)
	);

endmodule

`default_nettype wire

//--- sim/rv_idexe_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idexe_chk (
	input wire logic clk,
	input wire logic reset,
	input wire logic flush,
	input wire logic busy,
	input wire logic res_valid
);

	int run_len;
	int fail_cnt = 0;

	// length of the current busy stretch
	always_ff @(posedge clk) begin
		if (reset || !busy) begin
			run_len <= 0;
		end else begin
			run_len <= run_len + 1;
		end
	end

	a_reset_quiet: assert property (@(posedge clk) $past(reset) && !reset |-> !busy && !res_valid)
		else begin
			fail_cnt++;
			$error("busy or res_valid high right after reset");
		end

	// a flushed division ends early
	a_busy_len: assert property (@(posedge clk) disable iff (reset)
		!busy && $past(busy) && !$past(flush) |-> run_len == 33)
		else begin
			fail_cnt++;
			$error("busy stretch lasted %0d cycles", run_len);
		end

	a_no_res_busy: assert property (@(posedge clk) disable iff (reset) !(res_valid && busy))
		else begin
			fail_cnt++;
			$error("res_valid high while busy");
		end

endmodule

bind rv_idexe_top rv_idexe_chk rv_idexe_chk_i (
	.clk       (clk),
	.reset     (reset),
	.flush     (flush),
	.busy      (busy),
	.res_valid (res_valid)
);

`default_nettype wire

//--- sim/rv_idexe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_idexe_tb
	import rv_pkg::*;
();

	logic        clk;
	logic        reset;
	logic        in_valid;
	instr_u      instr;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic        flush;
	logic        busy;
	logic        res_valid;
	logic [4:0]  res_rd;
	logic [31:0] res_data;

	// stimulus table
	instr_u      row_instr[$];
	logic [31:0] row_a[$];
	logic [31:0] row_b[$];
	bit          row_flush[$];

	// expected results in acceptance order
	logic [4:0]  exp_rd[$];
	logic [31:0] exp_data[$];
	int          exp_cyc[$];

	int cyc = 0;
	int limit = 1000000;
	int err_mismatch = 0;
	int err_other = 0;

	rv_idexe_top rv_idexe_top_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.instr     (instr),
		.op_a      (op_a),
		.op_b      (op_b),
		.flush     (flush),
		.busy      (busy),
		.res_valid (res_valid),
		.res_rd    (res_rd),
		.res_data  (res_data)
	);

	always #2 clk = ~clk;

	function automatic instr_u make_r(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd);
		instr_u w;
		w.r.funct7 = f7;
		w.r.rs2    = 5'd2;
		w.r.rs1    = 5'd1;
		w.r.funct3 = f3;
		w.r.rd     = rd;
		w.r.opcode = OPC_OP;
		return w;
	endfunction

	function automatic instr_u make_i(input logic [11:0] imm, input logic [2:0] f3,
			input logic [4:0] rd);
		instr_u w;
		w.i.imm12  = imm;
		w.i.rs1    = 5'd1;
		w.i.funct3 = f3;
		w.i.rd     = rd;
		w.i.opcode = OPC_OP_IMM;
		return w;
	endfunction

	task automatic add_row(input instr_u w, input logic [31:0] a, input logic [31:0] b,
			input bit fl);
		row_instr.push_back(w);
		row_a.push_back(a);
		row_b.push_back(b);
		row_flush.push_back(fl);
	endtask

	// base integer ops by funct3, alt selects SUB and SRA
	function automatic logic [31:0] base_op(input logic [2:0] f3, input bit alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] div_ref(input div_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		bit ovf;
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			DIV:  return (b == 0) ? 32'hffff_ffff : ovf ? a : 32'($signed(a) / $signed(b));
			DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
			REM:  return (b == 0) ? a : ovf ? 32'd0 : 32'($signed(a) % $signed(b));
			default: return (b == 0) ? a : a % b;
		endcase
	endfunction

	task automatic predict(input instr_u w, input logic [31:0] a, input logic [31:0] b,
			output bit has, output bit is_div, output logic [31:0] val);
		logic [31:0] imm;
		logic [6:0]  hi;
		bit          ok;
		ok     = 0;
		is_div = 0;
		val    = '0;
		imm    = {{20{w.i.imm12[11]}}, w.i.imm12};
		hi     = w.i.imm12[11:5];
		if (w.r.opcode == OPC_OP) begin
			if (w.r.funct7 == 7'h00) begin
				ok  = 1;
				val = base_op(w.r.funct3, 0, a, b);
			end else if (w.r.funct7 == 7'h20 && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5)) begin
				ok  = 1;
				val = base_op(w.r.funct3, 1, a, b);
			end else if (w.r.funct7 == 7'h01 && w.r.funct3[2]) begin
				ok     = 1;
				is_div = 1;
				val    = div_ref(div_op_e'(w.r.funct3[1:0]), a, b);
			end
		end else if (w.i.opcode == OPC_OP_IMM) begin
			if (w.i.funct3 == 3'd1 || w.i.funct3 == 3'd5) begin
				ok  = (hi == 7'h00) || (w.i.funct3 == 3'd5 && hi == 7'h20);
				val = base_op(w.i.funct3, hi == 7'h20, a, {27'd0, w.i.imm12[4:0]});
			end else begin
				ok  = 1;
				val = base_op(w.i.funct3, 0, a, imm);
			end
		end
		has = ok && (w.r.rd != 5'd0);
	endtask

	task automatic check_rd(input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch at %0t: res_rd got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch at %0t: res_data got %08h expected %08h", $time, got, exp);
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch at %0t: busy got %0b expected %0b", $time, got, exp);
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			err_mismatch++;
			$display("Mismatch at %0t: result cycle got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_quiet();
		err_other++;
		$display("%0t: a result came out for rd %0d while none was expected", $time, res_rd);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= limit) begin
			$display("timeout after %0d cycles, results still missing", cyc);
			$display("TB FAILED");
			$finish;
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!reset && res_valid) begin
			if (exp_rd.size() == 0) begin
				check_quiet();
			end else begin
				check_rd(res_rd, exp_rd.pop_front());
				check_data(res_data, exp_data.pop_front());
				check_latency(cyc, exp_cyc.pop_front());
			end
		end
	end

	initial begin
		int          seed_val;
		bit          has;
		bit          is_div;
		bit          accepted;
		bit          last_div;
		int          n;
		int          busy_from;
		int          busy_to;
		int          err_assert;
		logic [31:0] val;
		seed_val  = $urandom(32'h7bdb);
		clk       = 0;
		reset     = 1;
		in_valid  = 0;
		instr     = '0;
		op_a      = '0;
		op_b      = '0;
		flush     = 0;
		last_div  = 0;
		busy_from = 1;
		busy_to   = 0;

		// the ten register ops
		add_row(make_r(7'h00, 3'd0, 5'd1), 32'd100, 32'd23, 0);
		add_row(make_r(7'h20, 3'd0, 5'd2), 32'd5, 32'd9, 0);
		add_row(make_r(7'h00, 3'd7, 5'd3), 32'hf0f0_1234, 32'h0ff0_ff00, 0);
		add_row(make_r(7'h00, 3'd6, 5'd4), 32'hf000_0001, 32'h0000_0f10, 0);
		add_row(make_r(7'h00, 3'd4, 5'd5), 32'haaaa_5555, 32'hffff_0000, 0);
		add_row(make_r(7'h00, 3'd1, 5'd6), 32'h0000_0003, 32'h0000_0024, 0);
		add_row(make_r(7'h00, 3'd5, 5'd7), 32'h8000_0000, 32'd4, 0);
		add_row(make_r(7'h20, 3'd5, 5'd8), 32'h8000_0000, 32'd4, 0);
		add_row(make_r(7'h00, 3'd2, 5'd9), 32'hffff_fffe, 32'd1, 0);
		add_row(make_r(7'h00, 3'd3, 5'd10), 32'hffff_fffe, 32'd1, 0);
		for (int k = 0; k < 8; k++) begin
			n = $urandom % 8;
			add_row(make_r(((n == 0 || n == 5) && k[0]) ? 7'h20 : 7'h00, n[2:0], 5'(11 + k)),
				$urandom, $urandom, 0);
		end
		// immediates, op_b on the port must be ignored
		add_row(make_i(12'hff6, 3'd0, 5'd1), 32'd3, 32'hdead_beef, 0);
		add_row(make_i(12'h800, 3'd2, 5'd2), 32'hffff_f000, 32'd0, 0);
		add_row(make_i(12'hfff, 3'd3, 5'd3), 32'd7, 32'd0, 0);
		add_row(make_i(12'h0f0, 3'd4, 5'd4), 32'h1234_5678, 32'd0, 0);
		add_row(make_i(12'h801, 3'd6, 5'd5), 32'd0, 32'd0, 0);
		add_row(make_i(12'h7ff, 3'd7, 5'd6), 32'hffff_ffff, 32'd0, 0);
		add_row(make_i(12'h01f, 3'd1, 5'd7), 32'd1, 32'd0, 0);
		add_row(make_i(12'h008, 3'd5, 5'd8), 32'hf000_0000, 32'd0, 0);
		add_row(make_i(12'h408, 3'd5, 5'd9), 32'hf000_0000, 32'd0, 0);
		// divides, back to back with an ALU op
		add_row(make_r(7'h01, 3'd4, 5'd10), 32'hffff_ff9c, 32'd7, 0);
		add_row(make_r(7'h00, 3'd0, 5'd11), 32'd1, 32'd2, 0);
		add_row(make_r(7'h01, 3'd5, 5'd12), 32'hffff_ff9c, 32'd7, 0);
		add_row(make_r(7'h01, 3'd6, 5'd13), 32'hffff_ff9c, 32'd7, 0);
		add_row(make_r(7'h01, 3'd7, 5'd14), 32'hffff_ff9c, 32'd7, 0);
		add_row(make_r(7'h01, 3'd4, 5'd15), 32'd55, 32'd0, 0);
		add_row(make_r(7'h01, 3'd7, 5'd16), 32'd55, 32'd0, 0);
		add_row(make_r(7'h01, 3'd4, 5'd17), 32'h8000_0000, 32'hffff_ffff, 0);
		add_row(make_r(7'h01, 3'd6, 5'd18), 32'h8000_0000, 32'hffff_ffff, 0);
		for (int k = 0; k < 4; k++) begin
			add_row(make_r(7'h01, 3'(4 + k), 5'(19 + k)), $urandom, $urandom >> k, 0);
		end
		// flush a division in progress
		add_row(make_r(7'h01, 3'd4, 5'd23), 32'd1000, 32'd3, 0);
		add_row('0, 32'd0, 32'd0, 1);
		add_row(make_r(7'h00, 3'd0, 5'd24), 32'd40, 32'd2, 0);
		// dropped instructions: load opcode, rd zero, multiply
		add_row(32'h0000_a283, 32'd1, 32'd2, 0);
		add_row(make_r(7'h00, 3'd0, 5'd0), 32'd1, 32'd2, 0);
		add_row(make_r(7'h01, 3'd4, 5'd0), 32'd9, 32'd3, 0);
		add_row(make_r(7'h01, 3'd0, 5'd25), 32'd9, 32'd3, 0);
		add_row(make_r(7'h00, 3'd4, 5'd26), 32'h0000_ffff, 32'h00ff_00ff, 0);
		limit = row_instr.size() * 40 + 100;

		repeat (3) @(posedge clk);
		#0.5 reset = 0;
		for (int i = 0; i < row_instr.size(); i++) begin
			if (row_flush[i]) begin
				in_valid = 0;
				repeat (10) @(posedge clk);
				#0.5 flush = 1;
				@(posedge clk);
				#0.5 flush = 0;
				if (last_div) begin
					void'(exp_rd.pop_back());
					void'(exp_data.pop_back());
					void'(exp_cyc.pop_back());
				end
				last_div = 0;
				busy_to  = 0;
			end else begin
				instr    = row_instr[i];
				op_a     = row_a[i];
				op_b     = row_b[i];
				in_valid = 1;
				do begin
					@(negedge clk);
					check_busy(busy, cyc >= busy_from && cyc <= busy_to);
					accepted = !busy;
					n        = cyc;
					@(posedge clk);
				end while (!accepted);
				#0.5;
				predict(row_instr[i], row_a[i], row_b[i], has, is_div, val);
				if (has) begin
					exp_rd.push_back(row_instr[i].r.rd);
					exp_data.push_back(val);
					exp_cyc.push_back(is_div ? n + 34 : n + 1);
				end
				// a divide holds the front for 33 cycles after acceptance
				if (has && is_div) begin
					busy_from = n + 1;
					busy_to   = n + 33;
				end
				last_div = has && is_div;
			end
		end
		in_valid = 0;
		while (exp_rd.size() != 0) begin
			@(posedge clk);
		end
		repeat (5) @(posedge clk);

		err_assert = rv_idexe_top_i.rv_idexe_chk_i.fail_cnt;
		$display("errors: %0d mismatches, %0d other, %0d assertions",
			err_mismatch, err_other, err_assert);
		if (err_mismatch == 0 && err_other == 0 && err_assert == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/rv_pkg.sv
design/decoded_if.sv
design/instr_decoder.sv
design/pipereg_id_exe.sv
design/div_ctrl_fsm.sv
design/div_step_counter.sv
design/div_datapath.sv
design/alu_unit.sv
design/rv_idexe_top.sv
sim/rv_idexe_chk.sv
sim/rv_idexe_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ID/EXE slice testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module rv_idexe_tb -o rv_idexe_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/rv_idexe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
	exit 0
fi
exit 1
